/* design/hockey_pkg.sv */
package hockey_pkg;

    typedef enum logic [3:0] {
        st_idle,
        st_countdown,
        st_serve_a,
        st_serve_b,
        st_travel_to_b,
        st_travel_to_a,
        st_respond_b,
        st_respond_a,
        st_goal_a,        // a scored
        st_goal_b,        // b scored
        st_game_over
    } game_state_e;

    typedef enum logic [1:0] {
        dir_straight = 2'd0,
        dir_up       = 2'd1,  // toward lane 4
        dir_down     = 2'd2   // toward lane 0
    } dir_e;

    typedef struct packed {
        logic [2:0] x;
        logic [2:0] y;
        dir_e       dir;
    } puck_t;

    typedef struct packed {
        logic [1:0] score_a;
        logic [1:0] score_b;
    } score_t;

    // segments a..g from msb down, a zero lights the segment
    typedef logic [6:0] seg_t;
    typedef seg_t [7:0] ssd_bank_t;  // digit 7 is the leftmost

    localparam logic [2:0] COURT_LAST = 3'd4;  // last x cell and last y lane
    localparam int WAIT_TICKS = 100;
    localparam int TIMER_W = $clog2(WAIT_TICKS + 1);
    localparam logic [1:0] WIN_SCORE = 2'd3;

    localparam seg_t SEG_DIGIT [0:4] = '{
        7'b0000001,
        7'b1001111,
        7'b0010010,
        7'b0000110,
        7'b1001100
    };

    localparam seg_t SEG_BLANK      = 7'b1111111;
    localparam seg_t SEG_DASH       = 7'b1111110;  // g only
    localparam seg_t SEG_ZERO_FRAME = 7'b0000001;  // everything but g

    localparam logic [4:0] LED_NONE      = 5'b00000;
    localparam logic [4:0] LED_ALL       = 5'b11111;
    localparam logic [4:0] LED_GAME_OVER = 5'b10101;

endpackage

/* design/game_fsm.sv */
module game_fsm import hockey_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_a,
    input  logic        btn_b,
    input  logic [2:0]  y_a,
    input  logic [2:0]  y_b,
    input  puck_t       puck,
    output game_state_e state,
    output score_t      score,
    output logic        serve_load,
    output logic        step,
    output logic        hit_load
);

    game_state_e        next_state;
    logic               turn_b;     // b won the opening press
    logic [TIMER_W-1:0] timer;
    logic               timed;
    logic               wait_done;
    logic               hit;
    logic               hit_now;
    logic               miss;

    assign timed = state inside {st_countdown, st_travel_to_b, st_travel_to_a,
                                 st_respond_b, st_respond_a, st_goal_a, st_goal_b};

    // last cycle of a wait
    assign wait_done = timed && (timer == TIMER_W'(WAIT_TICKS));

    // receiver on the puck lane with the button down
    always_comb begin
        case (state)
            st_respond_b: hit_now = btn_b && (y_b == puck.y);
            st_respond_a: hit_now = btn_a && (y_a == puck.y);
            default:      hit_now = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        serve_load = 1'b0;
        step       = 1'b0;
        hit_load   = 1'b0;
        miss       = 1'b0;

        case (state)
            st_idle: begin
                if (btn_a != btn_b) begin
                    next_state = st_countdown;
                end
            end

            st_countdown: begin
                if (wait_done) begin
                    next_state = turn_b ? st_serve_b : st_serve_a;
                end
            end

            st_serve_a: begin
                if (btn_a && y_a <= COURT_LAST) begin
                    serve_load = 1'b1;
                    next_state = st_travel_to_b;
                end
            end

            st_serve_b: begin
                if (btn_b && y_b <= COURT_LAST) begin
                    serve_load = 1'b1;
                    next_state = st_travel_to_a;
                end
            end

            st_travel_to_b: begin
                if (wait_done) begin
                    step = 1'b1;
                    if (puck.x >= COURT_LAST - 3'd1) begin  // this step lands on b's edge
                        next_state = st_respond_b;
                    end
                end
            end

            st_travel_to_a: begin
                if (wait_done) begin
                    step = 1'b1;
                    if (puck.x <= 3'd1) begin
                        next_state = st_respond_a;
                    end
                end
            end

            st_respond_b: begin
                if (wait_done) begin
                    if (hit || hit_now) begin
                        hit_load   = 1'b1;
                        next_state = st_travel_to_a;
                    end else begin
                        miss       = 1'b1;
                        next_state = st_goal_a;
                    end
                end
            end

            st_respond_a: begin
                if (wait_done) begin
                    if (hit || hit_now) begin
                        hit_load   = 1'b1;
                        next_state = st_travel_to_b;
                    end else begin
                        miss       = 1'b1;
                        next_state = st_goal_b;
                    end
                end
            end

            // score already counted on the way in
            st_goal_a: begin
                if (wait_done) begin
                    next_state = (score.score_a == WIN_SCORE) ? st_game_over : st_serve_b;
                end
            end

            st_goal_b: begin
                if (wait_done) begin
                    next_state = (score.score_b == WIN_SCORE) ? st_game_over : st_serve_a;
                end
            end

            st_game_over: next_state = st_game_over;  // only rst leaves

            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            turn_b <= 1'b0;
            timer  <= '0;
            hit    <= 1'b0;
            score  <= '0;
        end else begin
            state <= next_state;

            if (state == st_idle && btn_a != btn_b) begin
                turn_b <= btn_b;
            end

            if (wait_done || next_state != state) begin
                timer <= '0;
            end else if (timed) begin
                timer <= timer + 1'b1;
            end

            if (!(state inside {st_respond_a, st_respond_b})) begin
                hit <= 1'b0;
            end else if (hit_now) begin
                hit <= 1'b1;
            end

            if (miss) begin
                if (state == st_respond_b) begin
                    score.score_a <= score.score_a + 2'd1;
                end else begin
                    score.score_b <= score.score_b + 2'd1;
                end
            end
        end
    end

endmodule

/* design/puck_motion.sv */
module puck_motion import hockey_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_e state,
    input  logic        serve_load,
    input  logic        step,
    input  logic        hit_load,
    input  logic [2:0]  y_a,
    input  logic [2:0]  y_b,
    input  dir_e        dir_a,
    input  dir_e        dir_b,
    output puck_t       puck
);

    logic       from_a;
    logic [2:0] serve_x;
    logic [2:0] serve_y;
    dir_e       serve_dir;
    dir_e       raw_dir;

    assign from_a = (state == st_serve_a);

    always_comb begin
        serve_x = from_a ? 3'd0 : COURT_LAST;
        serve_y = from_a ? y_a : y_b;
        raw_dir = from_a ? dir_a : dir_b;
        // an undefined code on the switches serves straight
        if (raw_dir inside {dir_up, dir_down}) begin
            serve_dir = raw_dir;
        end else begin
            serve_dir = dir_straight;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            puck <= '0;
        end else if (serve_load) begin
            puck.x   <= serve_x;
            puck.y   <= serve_y;
            puck.dir <= serve_dir;
        end else if (hit_load) begin
            // return cell one in from the receiver's edge
            puck.x <= (state == st_respond_b) ? COURT_LAST - 3'd1 : 3'd1;
        end else if (step) begin
            if (state == st_travel_to_b) begin
                puck.x <= puck.x + 3'd1;
            end else begin
                puck.x <= puck.x - 3'd1;
            end

            case (puck.dir)
                dir_up: begin
                    if (puck.y == COURT_LAST) begin
                        puck.dir <= dir_down;  // bounce, lane held this step
                    end else begin
                        puck.y <= puck.y + 3'd1;
                    end
                end
                dir_down: begin
                    if (puck.y == 3'd0) begin
                        puck.dir <= dir_up;
                    end else begin
                        puck.y <= puck.y - 3'd1;
                    end
                end
                default: puck.y <= puck.y;
            endcase
        end
    end

endmodule

/* design/display_drive.sv */
module display_drive import hockey_pkg::*; (
    input  game_state_e state,
    input  puck_t       puck,
    input  score_t      score,
    input  logic [2:0]  y_a,
    input  logic [2:0]  y_b,
    input  dir_e        dir_a,
    input  dir_e        dir_b,
    output logic        led_a,
    output logic        led_b,
    output logic [4:0]  led_x,
    output ssd_bank_t   ssd
);

    // lanes past 4 show nothing
    function automatic seg_t lane_seg(input logic [2:0] v);
        if (v <= COURT_LAST) begin
            return SEG_DIGIT[v];
        end
        return SEG_BLANK;
    endfunction

    function automatic seg_t dir_seg(input dir_e d);
        if (d inside {dir_straight, dir_up, dir_down}) begin
            return SEG_DIGIT[{1'b0, d}];
        end
        return SEG_BLANK;
    endfunction

    always_comb begin
        led_a = 1'b0;
        led_b = 1'b0;
        led_x = LED_NONE;

        case (state)
            st_idle: begin
                led_a = 1'b1;
                led_b = 1'b1;
            end
            st_serve_a:   led_a = 1'b1;
            st_serve_b:   led_b = 1'b1;
            st_travel_to_b,
            st_travel_to_a: led_x = 5'b10000 >> puck.x;  // x 0 sits on bit 4
            st_respond_a: begin
                led_a = 1'b1;
                led_x = 5'b00010;
            end
            st_respond_b: begin
                led_b = 1'b1;
                led_x = 5'b10000;
            end
            st_countdown,
            st_goal_a,
            st_goal_b:    led_x = LED_ALL;
            st_game_over: led_x = LED_GAME_OVER;
            default:      led_x = LED_NONE;
        endcase
    end

    always_comb begin
        ssd[7]   = lane_seg(y_b);
        ssd[6]   = lane_seg(y_a);
        ssd[5]   = lane_seg(puck.y);
        ssd[4:0] = {5{SEG_BLANK}};

        case (state)
            st_countdown: begin
                // serve directions while the players get ready
                ssd[4] = dir_seg(dir_a);
                ssd[3] = dir_seg(dir_b);
                ssd[2] = SEG_ZERO_FRAME;
                ssd[1] = SEG_ZERO_FRAME;
                ssd[0] = SEG_ZERO_FRAME;
            end
            st_goal_a,
            st_goal_b: begin
                ssd[4] = SEG_ZERO_FRAME;
                ssd[3] = SEG_ZERO_FRAME;
                ssd[2] = SEG_DIGIT[score.score_a];
                ssd[1] = SEG_DASH;
                ssd[0] = SEG_DIGIT[score.score_b];
            end
            st_game_over: begin
                ssd[4] = SEG_DIGIT[score.score_a];
                ssd[3] = SEG_ZERO_FRAME;
                ssd[2] = SEG_ZERO_FRAME;
                ssd[1] = SEG_ZERO_FRAME;
                ssd[0] = SEG_DIGIT[score.score_b];
            end
            default: ssd[4:0] = {5{SEG_BLANK}};  // idle, serve, travel, respond
        endcase
    end

endmodule

/* design/hockey_top.sv */
module hockey_top import hockey_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_a,
    input  logic       btn_b,
    input  dir_e       dir_a,
    input  dir_e       dir_b,
    input  logic [2:0] y_a,
    input  logic [2:0] y_b,
    output logic       led_a,
    output logic       led_b,
    output logic [4:0] led_x,
    output ssd_bank_t  ssd
);

    game_state_e state;
    score_t      score;
    puck_t       puck;
    logic        serve_load;
    logic        step;
    logic        hit_load;

    game_fsm fsm_i (
        .clk        (clk),
        .rst        (rst),
        .btn_a      (btn_a),
        .btn_b      (btn_b),
        .y_a        (y_a),
        .y_b        (y_b),
        .puck       (puck),
        .state      (state),
        .score      (score),
        .serve_load (serve_load),
        .step       (step),
        .hit_load   (hit_load)
    );

    puck_motion puck_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .serve_load (serve_load),
        .step       (step),
        .hit_load   (hit_load),
        .y_a        (y_a),
        .y_b        (y_b),
        .dir_a      (dir_a),
        .dir_b      (dir_b),
        .puck       (puck)
    );

    display_drive disp_i (
        .state (state),
        .puck  (puck),
        .score (score),
        .y_a   (y_a),
        .y_b   (y_b),
        .dir_a (dir_a),
        .dir_b (dir_b),
        .led_a (led_a),
        .led_b (led_b),
        .led_x (led_x),
        .ssd   (ssd)
    );

endmodule

/* test/clock_gen.sv */
module clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset for 3 cycles at start and again on each request
    always begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        wait (reset_req);
    end

endmodule

/* test/hockey_properties.sv */
module hockey_properties import hockey_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       btn_a,
    input logic       btn_b,
    input logic [2:0] y_a,
    input logic [2:0] y_b,
    input logic       led_a,
    input logic       led_b,
    input logic [4:0] led_x,
    input ssd_bank_t  ssd
);

    int unsigned error_count = 0;

    logic [4:0] led_x_q;
    logic       led_a_q;
    logic       led_b_q;
    logic       travel_q;
    logic       resp_q;
    logic       hit_seen;
    logic       hit_q;
    logic [2:0] lane_q;
    logic [1:0] run_dir;  // 1 toward b, 2 toward a
    logic [2:0] goal_a;
    logic [2:0] goal_b;

    logic       travel;
    logic       respond;
    logic       moved;
    logic       window_hit;
    logic       goal_entry;
    logic       game_over;
    logic [2:0] lane;

    function automatic logic [2:0] seg_lane(input seg_t s);
        for (int i = 0; i <= 4; i++) begin
            if (s == SEG_DIGIT[i]) begin
                return 3'(i);
            end
        end
        return 3'd7;  // not a lane digit
    endfunction

    assign lane       = seg_lane(ssd[5]);
    assign travel     = !led_a && !led_b && $onehot(led_x);
    assign respond    = (led_a && !led_b && led_x == 5'b00010) ||
                        (led_b && !led_a && led_x == 5'b10000);
    assign moved      = travel && travel_q && led_x != led_x_q;
    assign window_hit = hit_seen || (led_a && led_x == 5'b00010 && btn_a && y_a == lane) ||
                        (led_b && led_x == 5'b10000 && btn_b && y_b == lane);
    assign goal_entry = led_x == LED_ALL && led_a_q != led_b_q;  // straight out of a window
    assign game_over  = led_x == LED_GAME_OVER;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_x_q  <= '0;
            led_a_q  <= 1'b1;
            led_b_q  <= 1'b1;
            travel_q <= 1'b0;
            resp_q   <= 1'b0;
            hit_seen <= 1'b0;
            hit_q    <= 1'b0;
            lane_q   <= '0;
            run_dir  <= 2'd0;
            goal_a   <= '0;
            goal_b   <= '0;
        end else begin
            led_x_q  <= led_x;
            led_a_q  <= led_a;
            led_b_q  <= led_b;
            travel_q <= travel;
            resp_q   <= respond;
            hit_seen <= respond && window_hit;
            hit_q    <= window_hit;
            lane_q   <= lane;
            if (!travel) begin
                run_dir <= 2'd0;
            end else if (moved && led_x == (led_x_q >> 1)) begin
                run_dir <= 2'd1;
            end else if (moved && led_x == (led_x_q << 1)) begin
                run_dir <= 2'd2;
            end
            if (goal_entry) begin
                goal_a <= seg_lane(ssd[2]);
                goal_b <= seg_lane(ssd[0]);
            end
        end
    end

    reset_idle: assert property (@(posedge clk)
        rst |-> led_a && led_b && led_x == 5'b0 && ssd[4:0] == {5{SEG_BLANK}})
        else begin
            $error("[FAIL] in reset led_a=%h led_b=%h led_x=%h ssd=%h", led_a, led_b, led_x, ssd);
            error_count++;
        end

    travel_step: assert property (@(posedge clk) disable iff (rst)
        moved |-> (led_x == (led_x_q >> 1) && run_dir != 2'd2) ||
                  (led_x == (led_x_q << 1) && run_dir != 2'd1))
        else begin
            $error("[FAIL] led_x=%h after %h", led_x, led_x_q);
            error_count++;
        end

    lane_valid: assert property (@(posedge clk) disable iff (rst) lane != 3'd7)
        else begin
            $error("[FAIL] ssd[5]=%h", ssd[5]);
            error_count++;
        end

    lane_step: assert property (@(posedge clk) disable iff (rst)
        moved |-> ((lane >= lane_q) ? lane - lane_q : lane_q - lane) <= 3'd1)
        else begin
            $error("[FAIL] ssd[5]=%h lane=%h after lane %h", ssd[5], lane, lane_q);
            error_count++;
        end

    // player lanes on the two leftmost digits
    input_lanes: assert property (@(posedge clk) disable iff (rst)
        ((y_b <= 3'd4) ? seg_lane(ssd[7]) == y_b : ssd[7] == SEG_BLANK) &&
        ((y_a <= 3'd4) ? seg_lane(ssd[6]) == y_a : ssd[6] == SEG_BLANK))
        else begin
            $error("[FAIL] ssd[7]=%h y_b=%h ssd[6]=%h y_a=%h", ssd[7], y_b, ssd[6], y_a);
            error_count++;
        end

    goal_score: assert property (@(posedge clk) disable iff (rst)
        goal_entry |-> ssd[1] == SEG_DASH &&
            ((seg_lane(ssd[2]) == goal_a + 3'd1 && seg_lane(ssd[0]) == goal_b) ||
             (seg_lane(ssd[2]) == goal_a && seg_lane(ssd[0]) == goal_b + 3'd1)))
        else begin
            $error("[FAIL] ssd[2:0]=%h after scores %h-%h", ssd[2:0], goal_a, goal_b);
            error_count++;
        end

    over_hold: assert property (@(posedge clk) disable iff (rst) game_over |=> game_over)
        else begin
            $error("[FAIL] led_x=%h left game over", led_x);
            error_count++;
        end

    over_score: assert property (@(posedge clk) disable iff (rst)
        game_over |-> ssd[4] == SEG_DIGIT[3] || ssd[0] == SEG_DIGIT[3])
        else begin
            $error("[FAIL] ssd[4]=%h ssd[0]=%h at game over", ssd[4], ssd[0]);
            error_count++;
        end

    return_travel: assert property (@(posedge clk) disable iff (rst)
        resp_q && hit_q && !respond |-> travel)
        else begin
            $error("[FAIL] led_x=%h led_a=%h led_b=%h after a hit", led_x, led_a, led_b);
            error_count++;
        end

endmodule

bind hockey_top hockey_properties props_i (.*);

/* test/tb_top.sv */
module tb_top import hockey_pkg::*; ();

    localparam int MAX_CYCLES = 80000;  // 2 games, 5 points, 6 rallies of 5 waits each

    logic       clk;
    logic       rst;
    logic       reset_req;
    logic       btn_a;
    logic       btn_b;
    dir_e       dir_a;
    dir_e       dir_b;
    logic [2:0] y_a;
    logic [2:0] y_b;
    logic       led_a;
    logic       led_b;
    logic [4:0] led_x;
    ssd_bank_t  ssd;

    int         cycle_count = 0;
    int         rally;
    logic       b_first;
    logic       in_window;
    logic [2:0] aim_lane;

    clock_gen clk_i (.reset_req(reset_req), .clk(clk), .rst(rst));

    hockey_top dut_i (.*);

    function automatic logic [2:0] shown_lane(input seg_t s);
        for (int i = 0; i <= 4; i++) begin
            if (s == SEG_DIGIT[i]) begin
                return 3'(i);
            end
        end
        return 3'd0;
    endfunction

    // both bots, one cycle of play
    task automatic play_cycle();
        logic [2:0] lane;
        logic       window;
        logic       aim_hit;
        @(posedge clk);
        #2;
        lane   = shown_lane(ssd[5]);
        window = (led_a && led_x == 5'b00010) || (led_b && led_x == 5'b10000);
        btn_a  = 1'b0;
        btn_b  = 1'b0;
        if (led_a && led_b && led_x == 5'b0) begin
            btn_a = !b_first;  // only one presses
            btn_b = b_first;
        end else if (led_x == 5'b0 && led_a) begin
            rally = 0;
            y_a   = 3'($urandom_range(4));
            dir_a = dir_e'($urandom_range(2));
            btn_a = 1'b1;
        end else if (led_x == 5'b0 && led_b) begin
            rally = 0;
            y_b   = 3'($urandom_range(4));
            dir_b = dir_e'($urandom_range(2));
            btn_b = 1'b1;
        end else if (window) begin
            if (!in_window) begin
                aim_hit  = rally < 5 && $urandom_range(99) < 65;  // rallies stay short
                rally    = aim_hit ? rally + 1 : 0;
                aim_lane = aim_hit ? lane : ((lane == 3'd4) ? 3'd0 : lane + 3'd1);
            end
            if (led_a) begin
                y_a   = aim_lane;
                btn_a = 1'b1;
            end else begin
                y_b   = aim_lane;
                btn_b = 1'b1;
            end
        end
        in_window = window;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (dut_i.props_i.error_count != 0) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "an assertion failed");
        end else if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no game over after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        btn_a     = 1'b0;
        btn_b     = 1'b0;
        dir_a     = dir_straight;
        dir_b     = dir_straight;
        y_a       = 3'd0;
        y_b       = 3'd0;
        reset_req = 1'b0;
        b_first   = 1'b0;
        rally     = 0;
        in_window = 1'b0;
        aim_lane  = 3'd0;
        void'($urandom(71));
        fork
            forever play_cycle();
        join_none

        wait (!rst);
        wait (led_x == LED_GAME_OVER);
        repeat (20) @(posedge clk);

        // second game, b opens
        b_first = 1'b1;
        #2 reset_req = 1'b1;
        wait (rst);
        reset_req = 1'b0;
        wait (!rst);
        wait (led_x == LED_GAME_OVER);
        repeat (20) @(posedge clk);
        #2;  // let the assertions of the last edge report

        if (dut_i.props_i.error_count != 0) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "an assertion failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* sim.f */
design/hockey_pkg.sv
design/game_fsm.sv
design/puck_motion.sv
design/display_drive.sv
design/hockey_top.sv
test/clock_gen.sv
test/hockey_properties.sv
test/tb_top.sv
